/* hdl/mult_pkg.sv */
`default_nettype none

package mult_pkg;

    // Operand width used unless the top level overrides it
    localparam int DEFAULT_OPERAND_WIDTH = 16;

    ////////////////////////////////
    // APB register offsets
    ////////////////////////////////
    localparam logic [11:0] ADDR_OPERAND_A = 12'h000;
    localparam logic [11:0] ADDR_OPERAND_B = 12'h004;
    localparam logic [11:0] ADDR_CTRL      = 12'h008;
    localparam logic [11:0] ADDR_PRODUCT   = 12'h00C;

    // Control word on write, status word on read
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        STEP = 2'd2
    } mult_state_t;

endpackage

`default_nettype wire

/* hdl/mult_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Register block to engine
interface mult_req_if #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
);
    logic                         start;
    logic [OPERAND_WIDTH-1:0]     operand_a;
    logic [OPERAND_WIDTH-1:0]     operand_b;
    logic                         busy;
    logic                         done;
    logic [2*OPERAND_WIDTH-1:0]   product;

    modport regs (output start, operand_a, operand_b, input busy, done, product);
    modport ctrl (input start, output busy, done);
    modport dp   (input operand_a, operand_b, output product);
endinterface

// One step per cycle from controller to datapath
interface mult_step_if #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
);
    localparam int SHIFT_WIDTH = $clog2(OPERAND_WIDTH);

    logic                   load;
    logic                   add_en;
    logic                   use_operand;
    logic                   negate;
    logic [SHIFT_WIDTH-1:0] shift_amount;
    logic                   b_bit;

    modport ctrl (
        output load, add_en, use_operand, negate, shift_amount,
        input  b_bit
    );
    modport dp (
        input  load, add_en, use_operand, negate, shift_amount,
        output b_bit
    );
endinterface

`default_nettype wire

/* hdl/mult_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_controller #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
) (
    input  wire       clk,
    input  wire       reset,
    mult_req_if.ctrl  req,
    mult_step_if.ctrl step
);
    import mult_pkg::*;

    localparam int COUNT_WIDTH = $clog2(OPERAND_WIDTH);
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(OPERAND_WIDTH - 1);

    mult_state_t            state;
    mult_state_t            state_next;
    logic [COUNT_WIDTH-1:0] bit_count;
    logic                   last_step;
    logic                   done_q;

    assign last_step = (state == STEP) && (bit_count == LAST_COUNT);

    ////////////////////////////////
    // Sequencer
    ////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (req.start) state_next = LOAD;
            LOAD: state_next = STEP;
            STEP: if (last_step) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= IDLE;
            bit_count <= '0;
            done_q    <= 1'b0;
        end else begin
            state  <= state_next;
            done_q <= last_step;
            if (state == LOAD) begin
                bit_count <= '0;
            end else if (state == STEP) begin
                bit_count <= bit_count + 1'b1;
            end
        end
    end

    // Bit position doubles as shift amount
    assign step.load         = (state == LOAD);
    assign step.add_en       = (state == STEP);
    assign step.use_operand  = (state == STEP) && step.b_bit;
    // Sign bit of the multiplier has negative weight
    assign step.negate       = last_step;
    assign step.shift_amount = bit_count;

    assign req.busy = (state != IDLE);
    assign req.done = done_q;

endmodule

`default_nettype wire

/* hdl/mult_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_datapath #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
) (
    input  wire     clk,
    input  wire     reset,
    mult_req_if.dp  req,
    mult_step_if.dp step
);
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    logic [PRODUCT_WIDTH-1:0] multiplicand;
    logic [OPERAND_WIDTH-1:0] multiplier;
    logic [PRODUCT_WIDTH-1:0] selected;
    logic [PRODUCT_WIDTH-1:0] signed_term;
    logic [PRODUCT_WIDTH-1:0] partial;
    logic [PRODUCT_WIDTH-1:0] accumulator;

    ////////////////////////////////
    // Partial product
    ////////////////////////////////
    always_comb begin
        selected    = step.use_operand ? multiplicand : '0;
        signed_term = step.negate ? (~selected + 1'b1) : selected;
        partial     = signed_term << step.shift_amount;
    end

    // Multiplier shifts right one bit per step
    always_ff @(posedge clk) begin
        if (step.load) begin
            multiplicand <= PRODUCT_WIDTH'($signed(req.operand_a));
            multiplier   <= req.operand_b;
        end else if (step.add_en) begin
            multiplier <= multiplier >> 1;
        end
    end

    ////////////////////////////////
    // Accumulator
    ////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            accumulator <= '0;
        end else if (step.load) begin
            accumulator <= '0;
        end else if (step.add_en) begin
            accumulator <= accumulator + partial;
        end
    end

    assign step.b_bit  = multiplier[0];
    assign req.product = accumulator;

endmodule

`default_nettype wire

/* hdl/apb_mult_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_mult_regs #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
) (
    input  wire         clk,
    input  wire         reset,
    input  wire  [11:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    mult_req_if.regs    req
);
    import mult_pkg::*;

    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    logic                     access;
    logic                     wr_access;
    logic                     rd_access;
    logic                     sel_a;
    logic                     sel_b;
    logic                     sel_ctrl;
    logic                     sel_product;
    logic                     addr_valid;
    logic                     engine_busy;
    logic                     start_request;
    logic                     start_refused;
    logic [OPERAND_WIDTH-1:0] operand_a_q;
    logic [OPERAND_WIDTH-1:0] operand_b_q;
    logic [PRODUCT_WIDTH-1:0] product_q;
    logic                     done_flag;
    logic                     start_q;
    logic [31:0]              status_word;

    ////////////////////////////////
    // Decode
    ////////////////////////////////
    assign access      = psel && penable;
    assign wr_access   = access && pwrite;
    assign rd_access   = access && !pwrite;
    assign sel_a       = (paddr == ADDR_OPERAND_A);
    assign sel_b       = (paddr == ADDR_OPERAND_B);
    assign sel_ctrl    = (paddr == ADDR_CTRL);
    assign sel_product = (paddr == ADDR_PRODUCT);
    assign addr_valid  = sel_a || sel_b || sel_ctrl || sel_product;

    // Start pulse is not yet visible as busy in its own cycle
    assign engine_busy   = req.busy || start_q;
    assign start_request = wr_access && sel_ctrl && pwdata[CTRL_START_BIT];
    assign start_refused = start_request && engine_busy;

    assign pready  = 1'b1;
    assign pslverr = access && (!addr_valid || (pwrite && sel_product) || start_refused);

    always_comb begin
        status_word                  = '0;
        status_word[STATUS_BUSY_BIT] = req.busy;
        status_word[STATUS_DONE_BIT] = done_flag;
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            if (sel_a) begin
                prdata = 32'($signed(operand_a_q));
            end else if (sel_b) begin
                prdata = 32'($signed(operand_b_q));
            end else if (sel_ctrl) begin
                prdata = status_word;
            end else if (sel_product) begin
                prdata = 32'($signed(product_q));
            end
        end
    end

    ////////////////////////////////
    // Registers
    ////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            operand_a_q <= '0;
            operand_b_q <= '0;
            product_q   <= '0;
            done_flag   <= 1'b0;
            start_q     <= 1'b0;
        end else begin
            start_q <= start_request && !engine_busy;
            if (wr_access && sel_a) operand_a_q <= pwdata[OPERAND_WIDTH-1:0];
            if (wr_access && sel_b) operand_b_q <= pwdata[OPERAND_WIDTH-1:0];
            if (req.done) product_q <= req.product;
            // Sticky until the next start
            if (start_q) begin
                done_flag <= 1'b0;
            end else if (req.done) begin
                done_flag <= 1'b1;
            end
        end
    end

    assign req.start     = start_q;
    assign req.operand_a = operand_a_q;
    assign req.operand_b = operand_b_q;

endmodule

`default_nettype wire

/* hdl/mult_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_top #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
) (
    input  wire         clk,
    input  wire         reset,
    input  wire  [11:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    mult_req_if  #(.OPERAND_WIDTH(OPERAND_WIDTH)) req_bus ();
    mult_step_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) step_bus ();

    ////////////////////////////////
    // APB side
    ////////////////////////////////
    apb_mult_regs #(
        .OPERAND_WIDTH(OPERAND_WIDTH)
    ) u_regs (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req_bus)
    );

    // Serial multiply engine
    mult_controller #(
        .OPERAND_WIDTH(OPERAND_WIDTH)
    ) u_controller (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus),
        .step  (step_bus)
    );

    mult_datapath #(
        .OPERAND_WIDTH(OPERAND_WIDTH)
    ) u_datapath (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus),
        .step  (step_bus)
    );

endmodule

`default_nettype wire

/* test/mult_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_sva #(
    parameter int OPERAND_WIDTH = mult_pkg::DEFAULT_OPERAND_WIDTH
) (
    input wire       clk,
    input wire       reset,
    input wire [1:0] state,
    input wire       start,
    input wire       busy,
    input wire       done,
    input wire       add_en
);
    import mult_pkg::*;

    // LOAD plus one STEP per multiplier bit
    localparam int BUSY_CYCLES = OPERAND_WIDTH + 1;

    busy_length: assert property (@(posedge clk) disable iff (!reset)
        start |=> busy [*BUSY_CYCLES] ##1 !busy)
        else $error("busy did not last %0d cycles after start", BUSY_CYCLES);

    done_pulse: assert property (@(posedge clk) disable iff (!reset)
        done |-> $fell(busy) ##1 !done)
        else $error("done is not a single pulse right after busy");

    // Neither in IDLE nor in the LOAD cycle that follows it
    add_in_step: assert property (@(posedge clk) disable iff (!reset)
        add_en |-> busy && ($past(mult_state_t'(state)) != IDLE))
        else $error("add_en high outside STEP");

endmodule

bind mult_controller mult_sva #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_sva (
    .clk    (clk),
    .reset  (reset),
    .state  (state),
    .start  (req.start),
    .busy   (req.busy),
    .done   (req.done),
    .add_en (step.add_en)
);

`default_nettype wire

/* test/tb_mult_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mult_top;
    import mult_pkg::*;

    localparam int    W            = DEFAULT_OPERAND_WIDTH;
    localparam int    RANDOM_COUNT = 200;
    localparam string TRACE_FILE   = "test/mult_trace.txt";

    logic        clk;
    logic        reset;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          cycle_count   = 0;
    int          timeout_limit = 0;
    int          access_cycle  = 0;
    int          error_count   = 0;
    int          pass_count    = 0;
    int          fail_count    = 0;
    bit          trace_ok;
    string       tag_q[$];
    string       kind_q[$];
    logic [31:0] v1_q[$];
    logic [31:0] v2_q[$];
    logic [31:0] v3_q[$];

    mult_top uut (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Limit is set once the trace length is known
    initial begin
        while (timeout_limit == 0 || cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////
    // Checking and reporting
    //////////////////////////////
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: FAILED", name);
        end
    endtask

    //////////////////////////////
    // APB transfers
    //////////////////////////////
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // Sample well before the closing edge
        #1;
        rdata        = prdata;
        err          = pslverr;
        access_cycle = cycle_count;
        check_value("pready", pready, 1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_status(input int bit_index, input logic level);
        logic [31:0] rdata;
        logic        err;
        do begin
            apb_access(1'b0, ADDR_CTRL, '0, rdata, err);
        end while (rdata[bit_index] !== level);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic multiply_operands(input logic [31:0] a_word, input logic [31:0] b_word,
                                     input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        int          start_cycle;
        wait_status(STATUS_BUSY_BIT, 1'b0);
        apb_access(1'b1, ADDR_OPERAND_A, a_word, rdata, err);
        check_value("pslverr on operand A write", err, 0);
        apb_access(1'b1, ADDR_OPERAND_B, b_word, rdata, err);
        check_value("pslverr on operand B write", err, 0);
        apb_access(1'b1, ADDR_CTRL, 32'h1 << CTRL_START_BIT, rdata, err);
        check_value("pslverr on start", err, 0);
        start_cycle = access_cycle;
        apb_access(1'b0, ADDR_CTRL, '0, rdata, err);
        check_value("busy after start", rdata[STATUS_BUSY_BIT], 1);
        check_value("done after start", rdata[STATUS_DONE_BIT], 0);
        wait_status(STATUS_DONE_BIT, 1'b1);
        check_value("done latency in range", (access_cycle - start_cycle) >= W + 2, 1);
        apb_access(1'b0, ADDR_PRODUCT, '0, rdata, err);
        check_value("product", rdata, expected);
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          count;
        string       line;
        string       tag;
        string       kind;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        fd = $fopen(TRACE_FILE, "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line  = "";
            count = $fgets(line, fd);
            kind  = "";
            if (count > 0 && line[0] != "#" && $sscanf(line, "%s", tag) == 1) begin
                if (tag == "M") begin
                    count = $sscanf(line, "%s %h %h %h", tag, v1, v2, v3);
                end else begin
                    count = $sscanf(line, "%s %s %h %h %h", tag, kind, v1, v2, v3);
                end
                tag_q.push_back(tag);
                kind_q.push_back(kind);
                v1_q.push_back(v1);
                v2_q.push_back(v2);
                v3_q.push_back(v3);
            end
        end
        if (ok) $fclose(fd);
    endtask

    task automatic replay_trace();
        logic [31:0] rdata;
        logic        err;
        int          errors_before;
        for (int i = 0; i < tag_q.size(); i++) begin
            errors_before = error_count;
            if (tag_q[i] == "M") begin
                multiply_operands(v1_q[i], v2_q[i], v3_q[i]);
            end else begin
                apb_access(kind_q[i] == "W", v1_q[i][11:0], v2_q[i], rdata, err);
                check_value("pslverr", err, v3_q[i]);
                if (kind_q[i] == "R") check_value("read data", rdata, v2_q[i]);
            end
            report_test($sformatf("trace line %0d (%s)", i, tag_q[i]), errors_before);
        end
    endtask

    // Second start during a run must leave the running product alone
    task automatic refuse_busy_start();
        logic [31:0] rdata;
        logic        err;
        int          errors_before;
        errors_before = error_count;
        wait_status(STATUS_BUSY_BIT, 1'b0);
        apb_access(1'b1, ADDR_OPERAND_A, 32'h0000_0003, rdata, err);
        apb_access(1'b1, ADDR_OPERAND_B, 32'h0000_0005, rdata, err);
        apb_access(1'b1, ADDR_CTRL, 32'h1 << CTRL_START_BIT, rdata, err);
        apb_access(1'b1, ADDR_OPERAND_A, 32'h0000_7FFF, rdata, err);
        apb_access(1'b1, ADDR_CTRL, 32'h1 << CTRL_START_BIT, rdata, err);
        check_value("pslverr on start while busy", err, 1);
        wait_status(STATUS_DONE_BIT, 1'b1);
        apb_access(1'b0, ADDR_PRODUCT, '0, rdata, err);
        check_value("product after refused start", rdata, 32'h0000_000F);
        report_test("refused start", errors_before);
    endtask

    task automatic random_products();
        logic [31:0]           a_word;
        logic [31:0]           b_word;
        logic signed [W-1:0]   a;
        logic signed [W-1:0]   b;
        logic signed [2*W-1:0] expected;
        int                    errors_before;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            errors_before = error_count;
            a_word        = $urandom();
            b_word        = $urandom();
            a             = a_word[W-1:0];
            b             = b_word[W-1:0];
            expected      = a * b;
            multiply_operands(a_word, b_word, 32'(expected));
            report_test($sformatf("random %0d (%0d x %0d)", i, a, b), errors_before);
        end
    endtask

    initial begin
        reset   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h9fe4));
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("could not open trace file %s", TRACE_FILE);
            $display("sim failed");
            $finish;
        end else begin
            timeout_limit = (tag_q.size() + RANDOM_COUNT) * 40 + 200;
            repeat (8) @(posedge clk);
            @(negedge clk);
            reset = 1'b1;
            replay_trace();
            refuse_busy_start();
            random_products();
            $display("tests: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0 && error_count == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
hdl/mult_pkg.sv
hdl/mult_if.sv
hdl/mult_controller.sv
hdl/mult_datapath.sv
hdl/apb_mult_regs.sv
hdl/mult_top.sv
test/mult_sva.sv
test/tb_mult_top.sv

/* test/mult_trace.txt */
# M a b product : multiply, hex operands and expected signed 32-bit product
# E kind addr data slverr : W writes data, R expects data, slverr is the expected error flag
M 0003 0005 0000000F
M 8000 8000 40000000
M FFFF 0001 FFFFFFFF
M 0000 1234 00000000
M 7FFF 7FFF 3FFF0001
M 7FFF 8000 C0008000
M FFFF FFFF 00000001
M 8000 0001 FFFF8000
E R 00C FFFF8000 0
E W 00C 12345678 1
E R 00C FFFF8000 0
E W 000 0000ABCD 0
E R 000 FFFFABCD 0
E W 004 12340042 0
E R 004 00000042 0
E W 008 00000001 0
E R 008 00000001 0
E W 008 00000001 1
E W 010 00000000 1
E R 014 00000000 1
M 0064 FF9C FFFFD8F0
